//--- htable_pkg.sv
// Hash table shared types, table geometry and request/response formats
package htable_pkg;

    // --------------------
    // Geometry
    // --------------------

    // Number of parallel tables searched on every lookup
    localparam int NUM_TABLES = 2;

    // Entries per table
    localparam int TABLE_DEPTH = 16;

    // Cycles from lookup strobe to lookup ack
    localparam int LOOKUP_LATENCY = 2;

    // Field widths
    localparam int KEY_W     = 16;
    localparam int VALUE_W   = 16;
    localparam int HASH_W    = $clog2(TABLE_DEPTH);
    localparam int TBL_IDX_W = $clog2(NUM_TABLES);

    // Rotation applied to the key per table index before folding
    localparam int HASH_ROT_STEP = 3;

    // --------------------
    // Scalar types
    // --------------------
    typedef logic [KEY_W-1:0]     key_t;
    typedef logic [VALUE_W-1:0]   value_t;
    typedef logic [HASH_W-1:0]    hash_t;
    typedef logic [TBL_IDX_W-1:0] tbl_idx_t;

    // One hash per table with table 0 in the low bits
    typedef hash_t [NUM_TABLES-1:0] hash_vec_t;

    // --------------------
    // Request / response
    // --------------------
    typedef struct packed {
        key_t key;
    } lookup_req_t;

    typedef struct packed {
        logic   hit;
        value_t value;
    } lookup_rsp_t;

    // Valid low turns the update into a delete
    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } update_req_t;

    // Stored entry format
    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } tbl_entry_t;

endpackage : htable_pkg

//--- htable_hash.sv
// Per-table rotate-and-fold hash of the lookup key and the update key
`timescale 1ns/1ps

module htable_hash (
    input  htable_pkg::key_t      lookup_key,
    input  htable_pkg::key_t      update_key,
    output htable_pkg::hash_vec_t lookup_hash,
    output htable_pkg::hash_vec_t update_hash
);
    import htable_pkg::*;

    // Rotate left, then XOR all hash-wide slices together
    function automatic hash_t fold_hash(input key_t key, input int unsigned rot);
        key_t  rkey;
        hash_t acc;
        rkey = (key << (rot % KEY_W)) | (key >> ((KEY_W - (rot % KEY_W)) % KEY_W));
        acc  = '0;
        for (int i = 0; i < KEY_W / HASH_W; i++) begin
            acc ^= rkey[i*HASH_W +: HASH_W];
        end
        return acc;
    endfunction

    // --------------------
    // One hash per table
    // --------------------
    // Each table uses its own rotation so colliding keys differ elsewhere
    generate
        for (genvar g_tbl = 0; g_tbl < NUM_TABLES; g_tbl++) begin : g_tbl_hash
            assign lookup_hash[g_tbl] = fold_hash(lookup_key, HASH_ROT_STEP * g_tbl);
            assign update_hash[g_tbl] = fold_hash(update_key, HASH_ROT_STEP * g_tbl);
        end : g_tbl_hash
    endgenerate

endmodule : htable_hash

//--- htable_core.sv
// Single hash table with power-up clear sweep and two-stage lookup/update pipelines
`timescale 1ns/1ps

module htable_core (
    input  logic                    clk,
    input  logic                    rst_n,

    output logic                    init_done,

    // Lookup side
    input  logic                    lookup_valid,
    input  htable_pkg::lookup_req_t lookup_req,
    input  htable_pkg::hash_t       lookup_hash,

    // Update side
    input  logic                    update_valid,
    input  htable_pkg::update_req_t update_req,
    input  htable_pkg::hash_t       update_hash,

    // Responses
    output logic                    lookup_ack,
    output htable_pkg::lookup_rsp_t lookup_rsp,
    output logic                    update_ack
);
    import htable_pkg::*;

    typedef enum logic {
        INIT_CLEAR,
        READY
    } state_t;

    state_t      state;
    hash_t       clr_idx;

    // Table storage
    tbl_entry_t  mem [TABLE_DEPTH];

    // Lookup stage 1
    logic        lkp_s1_valid;
    key_t        lkp_s1_key;
    hash_t       lkp_s1_hash;
    tbl_entry_t  rd_entry;

    // Update stage 1
    logic        upd_s1_valid;
    update_req_t upd_s1_req;
    hash_t       upd_s1_hash;
    tbl_entry_t  wr_entry;

    // --------------------
    // Init sweep
    // --------------------
    // One entry cleared per cycle, then READY until the next reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= INIT_CLEAR;
            clr_idx <= '0;
        end else begin
            case (state)
                INIT_CLEAR: begin
                    clr_idx <= clr_idx + hash_t'(1);
                    if (clr_idx == hash_t'(TABLE_DEPTH - 1)) begin
                        state <= READY;
                    end
                end
                default: state <= READY;
            endcase
        end
    end

    assign init_done = (state == READY);

    // --------------------
    // Pipeline control
    // --------------------
    // Strobes only count once the sweep is done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lkp_s1_valid <= 1'b0;
            upd_s1_valid <= 1'b0;
            lookup_ack   <= 1'b0;
            update_ack   <= 1'b0;
        end else begin
            lkp_s1_valid <= lookup_valid && init_done;
            upd_s1_valid <= update_valid && init_done;
            lookup_ack   <= lkp_s1_valid;
            update_ack   <= upd_s1_valid;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        lkp_s1_key  <= lookup_req.key;
        lkp_s1_hash <= lookup_hash;
        upd_s1_req  <= update_req;
        upd_s1_hash <= update_hash;
    end

    // --------------------
    // Array access
    // --------------------
    // Read sees the array before a write on the same edge
    assign rd_entry = mem[lkp_s1_hash];

    always_comb begin
        wr_entry.valid = upd_s1_req.valid;
        wr_entry.key   = upd_s1_req.key;
        wr_entry.value = upd_s1_req.value;
    end

    always_ff @(posedge clk) begin
        if (state == INIT_CLEAR) begin
            mem[clr_idx] <= '0;
        end else if (upd_s1_valid) begin
            mem[upd_s1_hash] <= wr_entry;
        end
    end

    // Hit needs a live entry holding the same key
    always_ff @(posedge clk) begin
        lookup_rsp.hit   <= rd_entry.valid && (rd_entry.key == lkp_s1_key);
        lookup_rsp.value <= rd_entry.value;
    end

endmodule : htable_core

//--- htable_multi_core.sv
// Multi-table hash engine with lookup fan-out, response merge and round-robin updates
`timescale 1ns/1ps

module htable_multi_core (
    input  logic                    clk,
    input  logic                    rst_n,

    output logic                    init_done,

    // Application requests
    input  logic                    lookup_valid,
    input  htable_pkg::lookup_req_t lookup_req,
    input  logic                    update_valid,
    input  htable_pkg::update_req_t update_req,

    // Hash loop
    output htable_pkg::key_t        lookup_key,
    output htable_pkg::key_t        update_key,
    input  htable_pkg::hash_vec_t   lookup_hash,
    input  htable_pkg::hash_vec_t   update_hash,

    // Merged responses
    output logic                    lookup_ack,
    output htable_pkg::lookup_rsp_t lookup_rsp,
    output logic                    update_ack
);
    import htable_pkg::*;

    logic [NUM_TABLES-1:0] core_init_done;
    logic [NUM_TABLES-1:0] core_upd_valid;
    logic [NUM_TABLES-1:0] core_lkp_ack;
    logic [NUM_TABLES-1:0] core_upd_ack;
    lookup_rsp_t           core_rsp [NUM_TABLES];

    // Round-robin update pointer
    tbl_idx_t              rr_ptr;
    logic                  upd_accept;

    // Same key feeds every table hash
    assign lookup_key = lookup_req.key;
    assign update_key = update_req.key;

    // --------------------
    // Table cores
    // --------------------
    generate
        for (genvar g_tbl = 0; g_tbl < NUM_TABLES; g_tbl++) begin : g_tbl_core
            // Only the table under the pointer takes the update
            assign core_upd_valid[g_tbl] = update_valid && (rr_ptr == tbl_idx_t'(g_tbl));

            htable_core i_htable_core (
                .clk          ( clk ),
                .rst_n        ( rst_n ),
                .init_done    ( core_init_done[g_tbl] ),
                .lookup_valid ( lookup_valid ),
                .lookup_req   ( lookup_req ),
                .lookup_hash  ( lookup_hash[g_tbl] ),
                .update_valid ( core_upd_valid[g_tbl] ),
                .update_req   ( update_req ),
                .update_hash  ( update_hash[g_tbl] ),
                .lookup_ack   ( core_lkp_ack[g_tbl] ),
                .lookup_rsp   ( core_rsp[g_tbl] ),
                .update_ack   ( core_upd_ack[g_tbl] )
            );
        end : g_tbl_core
    endgenerate

    // Ready only when every table finished its sweep
    assign init_done = &core_init_done;

    // --------------------
    // Update steering
    // --------------------
    assign upd_accept = update_valid && init_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (upd_accept) begin
            if (rr_ptr == tbl_idx_t'(NUM_TABLES - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= rr_ptr + tbl_idx_t'(1);
            end
        end
    end

    // Exactly one core acks a given update
    assign update_ack = |core_upd_ack;

    // --------------------
    // Response merge
    // --------------------
    // Later tables override earlier ones, so the highest hit wins
    always_comb begin
        lookup_ack = 1'b0;
        lookup_rsp = '0;
        for (int i = 0; i < NUM_TABLES; i++) begin
            if (core_lkp_ack[i]) begin
                lookup_ack = 1'b1;
                if (core_rsp[i].hit) begin
                    lookup_rsp.hit   = 1'b1;
                    lookup_rsp.value = core_rsp[i].value;
                end
            end
        end
    end

endmodule : htable_multi_core

//--- htable_top.sv
// Hash lookup engine top joining the table array and its hash block
`timescale 1ns/1ps

module htable_top (
    input  logic                    clk,
    input  logic                    rst_n,

    output logic                    init_done,

    // Application requests
    input  logic                    lookup_valid,
    input  htable_pkg::lookup_req_t lookup_req,
    input  logic                    update_valid,
    input  htable_pkg::update_req_t update_req,

    // Responses
    output logic                    lookup_ack,
    output htable_pkg::lookup_rsp_t lookup_rsp,
    output logic                    update_ack
);
    import htable_pkg::*;

    // Hash loop between the tables and the hash block
    key_t      lookup_key;
    key_t      update_key;
    hash_vec_t lookup_hash;
    hash_vec_t update_hash;

    // --------------------
    // Table array
    // --------------------
    htable_multi_core i_htable_multi_core (
        .clk          ( clk ),
        .rst_n        ( rst_n ),
        .init_done    ( init_done ),
        .lookup_valid ( lookup_valid ),
        .lookup_req   ( lookup_req ),
        .update_valid ( update_valid ),
        .update_req   ( update_req ),
        .lookup_key   ( lookup_key ),
        .update_key   ( update_key ),
        .lookup_hash  ( lookup_hash ),
        .update_hash  ( update_hash ),
        .lookup_ack   ( lookup_ack ),
        .lookup_rsp   ( lookup_rsp ),
        .update_ack   ( update_ack )
    );

    // Hashes return combinationally in the same cycle
    htable_hash i_htable_hash (
        .lookup_key  ( lookup_key ),
        .update_key  ( update_key ),
        .lookup_hash ( lookup_hash ),
        .update_hash ( update_hash )
    );

endmodule : htable_top

//--- htable_checker.sv
// Scoreboard for the hash engine, modeling both tables and checking init, acks and responses
`timescale 1ns/1ps

module htable_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    init_done,
    input  logic                    lookup_valid,
    input  htable_pkg::lookup_req_t lookup_req,
    input  logic                    update_valid,
    input  htable_pkg::update_req_t update_req,
    input  logic                    lookup_ack,
    input  htable_pkg::lookup_rsp_t lookup_rsp,
    input  logic                    update_ack,
    output int                      error_count,
    output int                      outstanding
);
    import htable_pkg::*;

    // Model tables and round-robin pointer
    tbl_entry_t  mdl [NUM_TABLES][TABLE_DEPTH];
    int          rr;
    int          edges;
    logic        ready;
    tbl_entry_t  ent;

    // Expected acks with the newest at index 0
    logic        exp_lkp [LOOKUP_LATENCY];
    logic        exp_upd [LOOKUP_LATENCY];
    lookup_rsp_t exp_rsp [LOOKUP_LATENCY];

    initial error_count = 0;

    // Rotate left by 3 bits per table via a doubled key, then XOR the nibbles
    function automatic hash_t index_of(input key_t key, input int tbl);
        logic [31:0] twice;
        key_t        rot;
        twice = {key, key};
        rot   = key_t'(twice >> (16 - 3 * tbl));
        return rot[3:0] ^ rot[7:4] ^ rot[11:8] ^ rot[15:12];
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        end
    endtask

    // --------------------
    // Prediction and compare
    // --------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edges       = 0;
            rr          = 0;
            outstanding = 0;
            for (int t = 0; t < NUM_TABLES; t++)
                for (int i = 0; i < TABLE_DEPTH; i++) mdl[t][i] = '0;
            for (int i = 0; i < LOOKUP_LATENCY; i++) begin
                exp_lkp[i] = 1'b0;
                exp_upd[i] = 1'b0;
                exp_rsp[i] = '0;
            end
        end else begin
            // Sweep takes one edge per entry
            edges++;
            ready = (edges > TABLE_DEPTH);
            compare("init_done", init_done, ready);
            compare("lookup_ack", lookup_ack, exp_lkp[LOOKUP_LATENCY-1]);
            compare("update_ack", update_ack, exp_upd[LOOKUP_LATENCY-1]);
            if (exp_lkp[LOOKUP_LATENCY-1] && lookup_ack === 1'b1) begin
                compare("lookup_rsp.hit", lookup_rsp.hit, exp_rsp[LOOKUP_LATENCY-1].hit);
                if (exp_rsp[LOOKUP_LATENCY-1].hit)
                    compare("lookup_rsp.value", lookup_rsp.value,
                            exp_rsp[LOOKUP_LATENCY-1].value);
            end
            for (int i = LOOKUP_LATENCY - 1; i > 0; i--) begin
                exp_lkp[i] = exp_lkp[i-1];
                exp_upd[i] = exp_upd[i-1];
                exp_rsp[i] = exp_rsp[i-1];
            end
            exp_lkp[0] = ready && lookup_valid;
            exp_upd[0] = ready && update_valid;
            exp_rsp[0] = '0;
            // Lookup first, so a same-cycle update stays invisible to it
            if (exp_lkp[0]) begin
                for (int t = 0; t < NUM_TABLES; t++) begin
                    ent = mdl[t][index_of(lookup_req.key, t)];
                    if (ent.valid && ent.key == lookup_req.key) begin
                        exp_rsp[0].hit   = 1'b1;
                        exp_rsp[0].value = ent.value;
                    end
                end
            end
            if (exp_upd[0]) begin
                ent.valid = update_req.valid;
                ent.key   = update_req.key;
                ent.value = update_req.value;
                mdl[rr][index_of(update_req.key, rr)] = ent;
                rr = (rr + 1) % NUM_TABLES;
            end
            outstanding = 0;
            for (int i = 0; i < LOOKUP_LATENCY; i++)
                outstanding += int'(exp_lkp[i]) + int'(exp_upd[i]);
        end
    end

endmodule : htable_checker

//--- tb_htable_top.sv
// Testbench for the hash lookup engine with seeded random lookups, updates and deletes
`timescale 1ns/1ps

module tb_htable_top;
    import htable_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        init_done;
    logic        lookup_valid;
    lookup_req_t lookup_req;
    logic        update_valid;
    update_req_t update_req;
    logic        lookup_ack;
    lookup_rsp_t lookup_rsp;
    logic        update_ack;
    int          error_count;
    int          outstanding;
    int          tb_errors;
    int          waited;

    // Small key pool so hash collisions and repeats are common
    key_t        key_pool [24];

    htable_top     dut (.*);
    htable_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Update fields first so the lookup can reuse the same key
    task automatic drive_random();
        update_valid     = ($urandom % 100) < 50;
        update_req.valid = ($urandom % 100) >= 20;
        update_req.key   = key_pool[$urandom % 24];
        update_req.value = value_t'($urandom);
        lookup_valid     = ($urandom % 100) < 60;
        lookup_req.key   = key_pool[$urandom % 24];
        if (($urandom % 4) == 0) lookup_req.key = update_req.key;
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        rst_n        = 1'b0;
        lookup_valid = 1'b0;
        lookup_req   = '0;
        update_valid = 1'b0;
        update_req   = '0;
        tb_errors    = 0;
        void'($urandom(32'hac9d));
        foreach (key_pool[i]) key_pool[i] = key_t'($urandom);
        // Two rising edges under reset, release on the falling edge after them
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Strobes during the clear sweep must be dropped
        @(negedge clk);
        drive_random();
        lookup_valid = 1'b1;
        update_valid = 1'b1;
        @(negedge clk);
        lookup_valid = 1'b0;
        update_valid = 1'b0;
        waited = 0;
        while (!init_done && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (!init_done) begin
            $display("init_done did not rise within 40 cycles after reset");
            tb_errors++;
        end
        repeat (400) begin
            drive_random();
            @(negedge clk);
        end
        lookup_valid = 1'b0;
        update_valid = 1'b0;
        // Drain the pipelines, then watch a few idle cycles for stray acks
        waited = 0;
        while (outstanding != 0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (outstanding != 0) begin
            $display("Acks still outstanding after the drain timeout");
            tb_errors++;
        end
        repeat (3) @(negedge clk);
        $display("Checker errors: %0d, testbench errors: %0d", error_count, tb_errors);
        if (error_count == 0 && tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : tb_htable_top

//--- src.f
htable_pkg.sv
htable_hash.sv
htable_core.sv
htable_multi_core.sv
htable_top.sv
htable_checker.sv
tb_htable_top.sv

//--- Bender.yml
package:
  name: htable

sources:
  - htable_pkg.sv
  - htable_hash.sv
  - htable_core.sv
  - htable_multi_core.sv
  - htable_top.sv
  - target: test
    files:
      - htable_checker.sv
      - tb_htable_top.sv
